/* rtl/render_pkg.sv */
/*
  Shared sizes, APB bundles, register layout and pipeline types for the
  single-layer tile renderer. Imported by every RTL module and by the
  testbench, so the screen format is defined here only.
*/
`default_nettype none

package render_pkg;

  // Display format, 640x480 shown as a doubled 320x240 image
  localparam int h_visible = 640;
  localparam int v_visible = 480;
  localparam int h_total = 800;
  localparam int screen_pos_width = 10;
  localparam int render_width = 320;
  localparam int tile_size = 16;

  // External memories
  localparam int map_addr_width = 10;
  localparam int map_data_width = 16;
  localparam int vram_addr_width = 16;
  localparam int vram_data_width = 16;
  // Palette index on top of the 8-bit pixel
  localparam int pal_addr_width = 12;
  // Red low byte, green, blue high byte
  localparam int pal_data_width = 24;
  localparam int rgb_width = 18;

  // Half select over a 9-bit x
  localparam int line_buf_addr_width = 10;
  // Render x issue to line buffer write
  localparam int render_delay = 4;

  localparam int apb_addr_width = 5;
  localparam int apb_data_width = 16;

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_width-1:0] prdata;
    logic pready;
    logic pslverr;
  } apb_rsp_t;

  // Register word addresses
  localparam logic [apb_addr_width-1:0] reg_ctrl = 5'd0;
  localparam logic [apb_addr_width-1:0] reg_scroll_x = 5'd1;
  localparam logic [apb_addr_width-1:0] reg_scroll_y = 5'd2;
  localparam logic [apb_addr_width-1:0] reg_color_key = 5'd3;
  localparam logic [apb_addr_width-1:0] reg_data_offset = 5'd4;

  // Control word, occupies bits 6:0
  typedef struct packed {
    logic layer_enable;
    logic flip_enable;
    logic transp_enable;
    logic [3:0] pal_index;
  } tile_ctrl_t;

  typedef struct packed {
    tile_ctrl_t ctrl;
    logic [apb_data_width-1:0] scroll_x;
    logic [apb_data_width-1:0] scroll_y;
    logic [apb_data_width-1:0] color_key;
    logic [apb_data_width-1:0] data_offset;
  } tile_regs_t;

  // Tilemap word, either a plain index or flip bits over a short index
  typedef union packed {
    logic [map_data_width-1:0] raw;
    struct packed {
      logic flip_xy;
      logic flip_y;
      logic flip_x;
      logic [12:0] index;
    } flip;
  } map_entry_t;

  typedef struct packed {
    logic active;
    logic [8:0] x;
    logic [7:0] line;
    logic half;
  } render_pos_t;

  typedef struct packed {
    logic valid;
    logic byte_sel;
    logic [line_buf_addr_width-1:0] buf_addr;
  } fetch_out_t;

endpackage

`default_nettype wire

/* rtl/tile_regs.sv */
/*
  APB slave for the tile layer registers. Five words at addresses 0 to 4,
  zero wait states. Anything above word 4 answers with pslverr and zero data
  and leaves the registers untouched.
*/
`default_nettype none

module tile_regs (
  input  logic                   clk,
  input  logic                   reset,
  input  render_pkg::apb_req_t   apb_req,
  output render_pkg::apb_rsp_t   apb_rsp,
  output render_pkg::tile_regs_t regs
);
  import render_pkg::*;

  logic addr_ok;
  logic access;
  logic [apb_data_width-1:0] rd_data;

  assign addr_ok = apb_req.paddr <= reg_data_offset;
  assign access = apb_req.psel && apb_req.penable;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (access && apb_req.pwrite && addr_ok) begin
      case (apb_req.paddr)
        reg_ctrl:        regs.ctrl <= tile_ctrl_t'(apb_req.pwdata[6:0]);
        reg_scroll_x:    regs.scroll_x <= apb_req.pwdata;
        reg_scroll_y:    regs.scroll_y <= apb_req.pwdata;
        reg_color_key:   regs.color_key <= apb_req.pwdata;
        default:         regs.data_offset <= apb_req.pwdata;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    case (apb_req.paddr)
      reg_ctrl:        rd_data = {9'd0, regs.ctrl};
      reg_scroll_x:    rd_data = regs.scroll_x;
      reg_scroll_y:    rd_data = regs.scroll_y;
      reg_color_key:   rd_data = regs.color_key;
      reg_data_offset: rd_data = regs.data_offset;
      default:         rd_data = '0;
    endcase
  end

  // Read data only while a read is selected
  assign apb_rsp.prdata = (apb_req.psel && !apb_req.pwrite) ? rd_data : '0;
  assign apb_rsp.pready = 1'b1;
  assign apb_rsp.pslverr = access && !addr_ok;

  // Access phase must follow a setup phase
  penable_after_setup: assert property (
    @(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel)
  );

endmodule

`default_nettype wire

/* rtl/render_control.sv */
/*
  Line pair sequencer. At h_pos 0 of every even visible line it starts a
  320 pixel render pass for the screen line v_pos/2, as long as the layer
  is enabled, and then waits for the next even line.
*/
`default_nettype none

module render_control (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic [render_pkg::screen_pos_width-1:0]  h_pos,
  input  logic [render_pkg::screen_pos_width-1:0]  v_pos,
  input  logic                                     layer_enable,
  output render_pkg::render_pos_t                  pos
);
  import render_pkg::*;

  logic start;
  logic last_x;

  assign start = layer_enable && (h_pos == '0) && (v_pos < v_visible) && !v_pos[0];
  assign last_x = pos.x == 9'(render_width - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pos <= '0;
    end else if (start) begin
      pos.active <= 1'b1;
      pos.x <= '0;
      // Screen line is v_pos/2, its low bit picks the buffer half
      pos.line <= v_pos[8:1];
      pos.half <= v_pos[1];
    end else if (pos.active) begin
      if (last_x) begin
        pos.active <= 1'b0;
        pos.x <= '0;
      end else begin
        pos.x <= pos.x + 9'd1;
      end
    end
  end

  x_in_range: assert property (
    @(posedge clk) disable iff (reset)
    pos.active |-> pos.x < render_width
  );

endmodule

`default_nettype wire

/* rtl/tile_fetch.sv */
/*
  Scroll, tilemap lookup, flip decode and video memory addressing.
  map_addr follows the render position in the same clock, map data comes
  back one clock later, vram_addr is registered after that and the fetch
  bundle lines up with the returning video memory word.
*/
`default_nettype none

module tile_fetch (
  input  logic                                    clk,
  input  logic                                    reset,
  input  render_pkg::render_pos_t                 pos,
  input  render_pkg::tile_regs_t                  regs,
  output logic [render_pkg::map_addr_width-1:0]   map_addr,
  input  logic [render_pkg::map_data_width-1:0]   map_data,
  output logic [render_pkg::vram_addr_width-1:0]  vram_addr,
  output render_pkg::fetch_out_t                  fetch
);
  import render_pkg::*;

  logic [8:0] world_x;
  logic [8:0] world_y;
  logic valid_q1;
  logic [line_buf_addr_width-1:0] buf_addr_q1;
  logic [3:0] tile_x_q;
  logic [3:0] tile_y_q;
  map_entry_t entry;
  logic flip_en;
  logic flip_x;
  logic flip_y;
  logic flip_xy;
  logic [3:0] tile_x_f;
  logic [3:0] tile_y_f;
  logic [map_data_width-1:0] tile_index;
  logic [vram_addr_width-1:0] vram_base;
  fetch_out_t stage2;

  // World coordinates wrap over the 512x512 map
  assign world_x = pos.x + regs.scroll_x[8:0];
  assign world_y = {1'b0, pos.line} + regs.scroll_y[8:0];
  assign map_addr = {5'(world_y / tile_size), 5'(world_x / tile_size)};

  // Flip bits only count when flipping is enabled
  assign entry = map_data;
  assign flip_en = regs.ctrl.flip_enable;
  assign flip_x = flip_en && entry.flip.flip_x;
  assign flip_y = flip_en && entry.flip.flip_y;
  assign flip_xy = flip_en && entry.flip.flip_xy;
  assign tile_index = flip_en ? map_data_width'(entry.flip.index) : entry.raw;

  always_comb begin
    if (flip_xy) begin
      // Transpose, then mirror
      tile_x_f = flip_y ? ~tile_y_q : tile_y_q;
      tile_y_f = flip_x ? ~tile_x_q : tile_x_q;
    end else begin
      tile_x_f = flip_x ? ~tile_x_q : tile_x_q;
      tile_y_f = flip_y ? ~tile_y_q : tile_y_q;
    end
  end

  // Two pixels per word, so x bit 0 picks the byte
  assign vram_base = vram_addr_width'({tile_index, tile_y_f, tile_x_f[3:1]});

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q1 <= 1'b0;
      buf_addr_q1 <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
      vram_addr <= '0;
      stage2 <= '0;
      fetch <= '0;
    end else begin
      valid_q1 <= pos.active;
      buf_addr_q1 <= {pos.half, pos.x};
      tile_x_q <= 4'(world_x % tile_size);
      tile_y_q <= 4'(world_y % tile_size);
      vram_addr <= vram_base + regs.data_offset[15:1];
      stage2.valid <= valid_q1;
      stage2.byte_sel <= tile_x_f[0];
      stage2.buf_addr <= buf_addr_q1;
      fetch <= stage2;
    end
  end

endmodule

`default_nettype wire

/* rtl/pixel_writer.sv */
/*
  Picks the pixel byte out of the video memory word, forms the palette
  address and writes the palette colour into the line buffer one clock
  later. Pixels matching the colour key are dropped when transparency is on.
*/
`default_nettype none

module pixel_writer (
  input  logic                                        clk,
  input  logic                                        reset,
  input  render_pkg::fetch_out_t                      fetch,
  input  logic [render_pkg::vram_data_width-1:0]      vram_data,
  input  render_pkg::tile_regs_t                      regs,
  output logic [render_pkg::pal_addr_width-1:0]       pal_addr,
  input  logic [render_pkg::pal_data_width-1:0]       pal_data,
  output logic                                        buf_wr,
  output logic [render_pkg::line_buf_addr_width-1:0]  buf_addr,
  output logic [render_pkg::pal_data_width-1:0]       buf_data
);
  import render_pkg::*;

  logic [7:0] pixel;
  logic valid_q;
  logic transp_q;
  logic [line_buf_addr_width-1:0] addr_q;

  assign pixel = fetch.byte_sel ? vram_data[15:8] : vram_data[7:0];
  assign pal_addr = {regs.ctrl.pal_index, pixel};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= fetch.valid;
    end
  end

  // Held for the palette read
  always_ff @(posedge clk) begin
    addr_q <= fetch.buf_addr;
    transp_q <= regs.ctrl.transp_enable && (pixel == regs.color_key[7:0]);
  end

  assign buf_wr = valid_q && !transp_q;
  assign buf_addr = addr_q;
  assign buf_data = pal_data;

endmodule

`default_nettype wire

/* rtl/line_scanout.sv */
/*
  Two-half line buffer and RGB output. The renderer fills one half while
  the other, rendered during the previous line pair, is scanned out with
  every pixel shown twice. Output is registered and zero in blanking.
*/
`default_nettype none

module line_scanout (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic [render_pkg::screen_pos_width-1:0]     h_pos,
  input  logic [render_pkg::screen_pos_width-1:0]     v_pos,
  input  logic                                        buf_wr,
  input  logic [render_pkg::line_buf_addr_width-1:0]  buf_addr,
  input  logic [render_pkg::pal_data_width-1:0]       buf_data,
  output logic [render_pkg::rgb_width-1:0]            rgb_out
);
  import render_pkg::*;

  logic [pal_data_width-1:0] line_buf [2**line_buf_addr_width];
  logic [line_buf_addr_width-1:0] rd_addr;
  logic [pal_data_width-1:0] rd_data;
  logic blank;

  always_ff @(posedge clk) begin
    if (buf_wr) begin
      line_buf[buf_addr] <= buf_data;
    end
  end

  // Screen y bit 0 is v_pos bit 1, read the half not being rendered
  assign rd_addr = {~v_pos[1], h_pos[9:1]};
  assign rd_data = line_buf[rd_addr];
  assign blank = (h_pos >= h_visible) || (v_pos >= v_visible);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rgb_out <= '0;
    end else if (blank) begin
      rgb_out <= '0;
    end else begin
      // Six bits each of blue, green, red
      rgb_out <= {rd_data[23:18], rd_data[15:10], rd_data[7:2]};
    end
  end

endmodule

`default_nettype wire

/* rtl/tile_renderer.sv */
/*
  Top level of the tile renderer. Connects the APB register block and the
  render pipeline control, fetch, writer and scanout. Tilemap, video memory
  and palette are external synchronous-read memories clocked by clk.
*/
`default_nettype none

module tile_renderer (
  input  logic                                     clk,
  input  logic                                     reset,
  input  render_pkg::apb_req_t                     apb_req,
  output render_pkg::apb_rsp_t                     apb_rsp,
  input  logic [render_pkg::screen_pos_width-1:0]  h_pos,
  input  logic [render_pkg::screen_pos_width-1:0]  v_pos,
  output logic [render_pkg::map_addr_width-1:0]    map_addr,
  input  logic [render_pkg::map_data_width-1:0]    map_data,
  output logic [render_pkg::vram_addr_width-1:0]   vram_addr,
  input  logic [render_pkg::vram_data_width-1:0]   vram_data,
  output logic [render_pkg::pal_addr_width-1:0]    pal_addr,
  input  logic [render_pkg::pal_data_width-1:0]    pal_data,
  output logic [render_pkg::rgb_width-1:0]         rgb_out
);
  import render_pkg::*;

  tile_regs_t regs;
  render_pos_t pos;
  fetch_out_t fetch;
  logic buf_wr;
  logic [line_buf_addr_width-1:0] buf_addr;
  logic [pal_data_width-1:0] buf_data;

  tile_regs u_regs (
    .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp), .regs(regs)
  );

  render_control u_control (
    .clk(clk), .reset(reset), .h_pos(h_pos), .v_pos(v_pos),
    .layer_enable(regs.ctrl.layer_enable), .pos(pos)
  );

  tile_fetch u_fetch (
    .clk(clk), .reset(reset), .pos(pos), .regs(regs),
    .map_addr(map_addr), .map_data(map_data), .vram_addr(vram_addr), .fetch(fetch)
  );

  pixel_writer u_writer (
    .clk(clk), .reset(reset), .fetch(fetch), .vram_data(vram_data), .regs(regs),
    .pal_addr(pal_addr), .pal_data(pal_data),
    .buf_wr(buf_wr), .buf_addr(buf_addr), .buf_data(buf_data)
  );

  line_scanout u_scanout (
    .clk(clk), .reset(reset), .h_pos(h_pos), .v_pos(v_pos),
    .buf_wr(buf_wr), .buf_addr(buf_addr), .buf_data(buf_data), .rgb_out(rgb_out)
  );

endmodule

`default_nettype wire

/* verification/tile_renderer_tb.sv */
/*
  Testbench for the tile renderer. Tilemap, video memory and palette models
  hold random contents and answer one clock after the address. Each row of
  the stimulus table is written over APB, then one render line pair and the
  following scanout line pair are driven and rgb_out is checked against a
  line buffer model built from the tile layer rules.
*/
`default_nettype none

module tile_renderer_tb;
  import render_pkg::*;

  typedef struct packed {
    tile_regs_t regs;
    logic [7:0] line;
  } stim_row_t;

  localparam int num_rows = 7;
  localparam int apb_timeout = 16;

  logic clk;
  logic reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic [screen_pos_width-1:0] h_pos;
  logic [screen_pos_width-1:0] v_pos;
  logic [map_addr_width-1:0] map_addr;
  logic [map_data_width-1:0] map_data;
  logic [vram_addr_width-1:0] vram_addr;
  logic [vram_data_width-1:0] vram_data;
  logic [pal_addr_width-1:0] pal_addr;
  logic [pal_data_width-1:0] pal_data;
  logic [rgb_width-1:0] rgb_out;

  logic [map_data_width-1:0] map_mem [2**map_addr_width];
  logic [vram_data_width-1:0] vram_mem [2**vram_addr_width];
  logic [pal_data_width-1:0] pal_mem [2**pal_addr_width];
  // Expected line buffer, one row per half
  logic [pal_data_width-1:0] buf_model [2][render_width];
  stim_row_t stim [num_rows];

  tile_renderer uut (
    .clk(clk), .reset(reset), .apb_req(apb_req), .apb_rsp(apb_rsp),
    .h_pos(h_pos), .v_pos(v_pos),
    .map_addr(map_addr), .map_data(map_data),
    .vram_addr(vram_addr), .vram_data(vram_data),
    .pal_addr(pal_addr), .pal_data(pal_data), .rgb_out(rgb_out)
  );

  always #2 clk = ~clk;

  // Synchronous read memories
  always @(posedge clk) begin
    map_data <= map_mem[map_addr];
    vram_data <= vram_mem[vram_addr];
    pal_data <= pal_mem[pal_addr];
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_rgb(input string name, input logic [rgb_width-1:0] got,
                           input logic [rgb_width-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_apb_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  task automatic check_data(input string name, input logic [apb_data_width-1:0] got,
                            input logic [apb_data_width-1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      stop_run();
    end
  endtask

  // Setup phase, access phase, then wait for pready
  task automatic apb_access(input logic write, input logic [apb_addr_width-1:0] addr,
                            input logic [apb_data_width-1:0] wdata, output apb_rsp_t rsp);
    int waited;
    waited = 0;
    @(posedge clk);
    apb_req <= apb_req_t'{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr,
                          pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready && waited < apb_timeout) begin
      waited++;
      @(negedge clk);
    end
    if (!apb_rsp.pready) begin
      $display("APB access to word %0d never completed", addr);
      stop_run();
    end
    rsp = apb_rsp;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic write_reg(input logic [apb_addr_width-1:0] addr,
                           input logic [apb_data_width-1:0] data);
    apb_rsp_t rsp;
    apb_access(1'b1, addr, data, rsp);
    check_apb_rsp("apb_rsp", rsp, apb_rsp_t'{prdata: '0, pready: 1'b1, pslverr: 1'b0});
  endtask

  task automatic read_reg(input logic [apb_addr_width-1:0] addr,
                          input logic [apb_data_width-1:0] exp);
    apb_rsp_t rsp;
    apb_access(1'b0, addr, '0, rsp);
    check_data("prdata", rsp.prdata, exp);
    check_apb_rsp("apb_rsp", rsp, apb_rsp_t'{prdata: exp, pready: 1'b1, pslverr: 1'b0});
  endtask

  task automatic apply_regs(input tile_regs_t r);
    write_reg(reg_ctrl, {9'd0, r.ctrl});
    write_reg(reg_scroll_x, r.scroll_x);
    write_reg(reg_scroll_y, r.scroll_y);
    write_reg(reg_color_key, r.color_key);
    write_reg(reg_data_offset, r.data_offset);
    read_reg(reg_ctrl, {9'd0, r.ctrl});
    read_reg(reg_scroll_x, r.scroll_x);
    read_reg(reg_scroll_y, r.scroll_y);
    read_reg(reg_color_key, r.color_key);
    read_reg(reg_data_offset, r.data_offset);
  endtask

  // Renders one screen line into the model half line[0]
  task automatic render_model(input tile_regs_t r, input int line);
    int wx, wy, tx, ty, px, py, index, word;
    logic [map_data_width-1:0] entry;
    logic [7:0] pixel;
    bit mx, my, swap;
    if (!r.ctrl.layer_enable) return;
    for (int x = 0; x < render_width; x++) begin
      wx = (x + r.scroll_x) % 512;
      wy = (line + r.scroll_y) % 512;
      entry = map_mem[(wy / tile_size) * 32 + wx / tile_size];
      tx = wx % tile_size;
      ty = wy % tile_size;
      index = entry;
      mx = 1'b0;
      my = 1'b0;
      swap = 1'b0;
      if (r.ctrl.flip_enable) begin
        index = entry[12:0];
        mx = entry[13];
        my = entry[14];
        swap = entry[15];
      end
      // Transposed tiles take the mirror bit of the other axis
      if (swap) begin
        px = my ? 15 - ty : ty;
        py = mx ? 15 - tx : tx;
      end else begin
        px = mx ? 15 - tx : tx;
        py = my ? 15 - ty : ty;
      end
      word = (index * 128 + py * 8 + px / 2 + r.data_offset / 2) % 65536;
      pixel = (px % 2 == 1) ? vram_mem[word][15:8] : vram_mem[word][7:0];
      if (!(r.ctrl.transp_enable && pixel == r.color_key[7:0])) begin
        buf_model[line % 2][x] = pal_mem[{r.ctrl.pal_index, pixel}];
      end
    end
  endtask

  // Drives two full lines, rgb_out trails the driven position by one clock
  task automatic drive_pair(input int first_v, input bit check_visible);
    logic [screen_pos_width-1:0] last_h;
    logic [screen_pos_width-1:0] last_v;
    logic [pal_data_width-1:0] colour;
    for (int v = first_v; v < first_v + 2; v++) begin
      for (int h = 0; h < h_total; h++) begin
        @(posedge clk);
        last_h = h_pos;
        last_v = v_pos;
        h_pos <= h;
        v_pos <= v;
        @(negedge clk);
        if (last_h >= h_visible || last_v >= v_visible) begin
          check_rgb("rgb_out", rgb_out, '0);
        end else if (check_visible) begin
          colour = buf_model[~last_v[1]][last_h[9:1]];
          check_rgb("rgb_out", rgb_out, {colour[23:18], colour[15:10], colour[7:2]});
        end
      end
    end
  endtask

  function automatic stim_row_t make_row(input int line, input bit le, input bit fe,
                                         input bit te, input logic [3:0] pal,
                                         input logic [15:0] sx, input logic [15:0] sy,
                                         input logic [15:0] key, input logic [15:0] off);
    stim_row_t row;
    row.line = line;
    row.regs.ctrl = tile_ctrl_t'{layer_enable: le, flip_enable: fe, transp_enable: te,
                                 pal_index: pal};
    row.regs.scroll_x = sx;
    row.regs.scroll_y = sy;
    row.regs.color_key = key;
    row.regs.data_offset = off;
    return row;
  endfunction

  initial begin
    int seed;
    apb_rsp_t rsp;
    clk = 1'b0;
    reset = 1'b1;
    apb_req = '0;
    h_pos = h_total - 1;
    v_pos = '0;
    map_data = '0;
    vram_data = '0;
    pal_data = '0;
    seed = $urandom(48);
    foreach (map_mem[i]) map_mem[i] = $urandom;
    // Pixels from 0 to 15 so the colour key hits often
    foreach (vram_mem[i]) vram_mem[i] = $urandom & 16'h0f0f;
    foreach (pal_mem[i]) pal_mem[i] = $urandom;
    foreach (buf_model[i, j]) buf_model[i][j] = '0;

    // line, layer, flip, transparency, palette, scroll x, scroll y, key, offset
    stim[0] = make_row(4, 1, 0, 0, 4'd3, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    stim[1] = make_row(20, 1, 0, 0, 4'd7, 16'h01f5, 16'h012c, 16'h0000, 16'h0246);
    stim[2] = make_row(33, 1, 1, 0, 4'd2, 16'h0005, 16'h0009, 16'h0000, 16'h0010);
    stim[3] = make_row(33, 1, 0, 0, 4'd2, 16'h0005, 16'h0009, 16'h0000, 16'h0010);
    stim[4] = make_row(60, 1, 0, 0, 4'd9, 16'h0003, 16'h0000, 16'h0005, 16'h0000);
    stim[5] = make_row(62, 1, 1, 1, 4'd9, 16'h0003, 16'h0000, 16'h0005, 16'h0000);
    stim[6] = make_row(64, 0, 0, 0, 4'd9, 16'h0003, 16'h0000, 16'h0005, 16'h0000);

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_rgb("rgb_out", rgb_out, '0);
    for (int a = 0; a <= 4; a++) begin
      read_reg(a, '0);
    end

    // Word 5 is outside the register map
    apb_access(1'b1, 5'd5, 16'hbeef, rsp);
    check_apb_rsp("apb_rsp", rsp, apb_rsp_t'{prdata: '0, pready: 1'b1, pslverr: 1'b1});
    apb_access(1'b0, 5'd5, '0, rsp);
    check_apb_rsp("apb_rsp", rsp, apb_rsp_t'{prdata: '0, pready: 1'b1, pslverr: 1'b1});
    // Registers still hold their reset values
    for (int a = 0; a <= 4; a++) begin
      read_reg(a, '0);
    end

    for (int i = 0; i < num_rows; i++) begin
      apply_regs(stim[i].regs);
      render_model(stim[i].regs, stim[i].line);
      render_model(stim[i].regs, stim[i].line + 1);
      drive_pair(2 * stim[i].line, 1'b0);
      drive_pair(2 * stim[i].line + 2, 1'b1);
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/render_pkg.sv
rtl/tile_regs.sv
rtl/render_control.sv
rtl/tile_fetch.sv
rtl/pixel_writer.sv
rtl/line_scanout.sv
rtl/tile_renderer.sv
verification/tile_renderer_tb.sv
